// File: joy_pkg.sv
`default_nettype none

package joy_pkg;

    localparam int MAX_PLAYERS = 4;

    // Raw board vector layout, active high
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;
    localparam int BTN_LSB   = 4;
    localparam int BTN_MSB   = 9;
    localparam int START_BIT = 10;
    localparam int COIN_BIT  = 11;
    localparam int PAUSE_BIT = 12;  // Bits 13 to 15 unused

    typedef logic [15:0]            board_joy_t;
    typedef logic [3:0]             dir_t;
    typedef logic [BTN_MSB-BTN_LSB:0] btn_t;
    typedef logic [9:0]             game_joy_t;    // Buttons above dirs
    typedef logic [MAX_PLAYERS-1:0] player_mask_t; // One bit per player

    // Synchronized player inputs, dirs in the low bits
    typedef struct packed {
        logic pause;
        logic coin;
        logic start;
        btn_t buttons;
        dir_t dirs;
    } player_sync_t;

endpackage

`default_nettype wire

// File: regs_pkg.sv
`default_nettype none

package regs_pkg;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Configuration levels plus one-cycle command pulses
    typedef struct packed {
        logic four_way;
        logic rotate;
        logic pause_pulse;
        logic reset_pulse;
    } ctrl_cmd_t;

    localparam apb_addr_t ADDR_CTRL   = 4'h0;
    localparam apb_addr_t ADDR_STATUS = 4'h4;

    localparam int CTRL_FOUR_WAY = 0;
    localparam int CTRL_ROTATE   = 1;
    localparam int CTRL_PAUSE    = 2;  // Write-one pulse, reads 0
    localparam int CTRL_RESET    = 3;  // Write-one pulse, reads 0
    localparam int STAT_PAUSE    = 0;
    localparam int STAT_GAME_RST = 1;

endpackage

`default_nettype wire

// File: apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs import regs_pkg::*; (
    input  wire       clk_sys,
    input  wire       rst,
    input  wire       apb_req_t apb_req,
    output apb_rsp_t  apb_rsp,
    input  wire       game_pause,
    input  wire       game_rst,
    output ctrl_cmd_t cmd
);

    logic access;
    logic addr_ok;
    logic wr_ctrl;

    assign access = apb_req.psel && apb_req.penable;

    // STATUS is read-only
    assign addr_ok = (apb_req.paddr == ADDR_CTRL) ||
                     ((apb_req.paddr == ADDR_STATUS) && !apb_req.pwrite);

    assign wr_ctrl = access && apb_req.pwrite && (apb_req.paddr == ADDR_CTRL);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            cmd <= '0;
        end else begin
            cmd.pause_pulse <= 1'b0;  // Pulses drop after one cycle
            cmd.reset_pulse <= 1'b0;
            if (wr_ctrl) begin
                cmd.four_way    <= apb_req.pwdata[CTRL_FOUR_WAY];
                cmd.rotate      <= apb_req.pwdata[CTRL_ROTATE];
                cmd.pause_pulse <= apb_req.pwdata[CTRL_PAUSE];
                cmd.reset_pulse <= apb_req.pwdata[CTRL_RESET];
            end
        end
    end

    // Zero wait states, response straight from the decode
    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && !addr_ok;
        if (apb_req.psel && !apb_req.pwrite) begin
            case (apb_req.paddr)
                ADDR_CTRL: begin
                    apb_rsp.prdata[CTRL_FOUR_WAY] = cmd.four_way;
                    apb_rsp.prdata[CTRL_ROTATE]   = cmd.rotate;
                end
                ADDR_STATUS: begin
                    apb_rsp.prdata[STAT_PAUSE]    = game_pause;
                    apb_rsp.prdata[STAT_GAME_RST] = game_rst;
                end
                default: apb_rsp.prdata = '0;
            endcase
        end
    end

    // Access phase only ever follows a setup phase
    apb_access_after_setup: assert property (@(posedge clk_sys) disable iff (rst)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable));

endmodule

`default_nettype wire

// File: input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module input_sync import joy_pkg::*; #(
    parameter int NUM_PLAYERS = 4
) (
    input  wire          clk_sys,
    input  wire          rst,
    input  wire          board_joy_t board_joy [NUM_PLAYERS],
    output player_sync_t player [NUM_PLAYERS]
);

    board_joy_t meta [NUM_PLAYERS];  // First flop stage

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                meta[i]   <= '0;
                player[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                meta[i] <= board_joy[i];
                // Second stage lands directly in the named fields
                player[i].dirs    <= meta[i][DIR_UP:DIR_RIGHT];
                player[i].buttons <= meta[i][BTN_MSB:BTN_LSB];
                player[i].start   <= meta[i][START_BIT];
                player[i].coin    <= meta[i][COIN_BIT];
                player[i].pause   <= meta[i][PAUSE_BIT];
            end
        end
    end

endmodule

`default_nettype wire

// File: joy_channel.sv
`timescale 1ns/1ps
`default_nettype none

module joy_channel import joy_pkg::*; #(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  wire       clk_sys,
    input  wire       rst,
    input  wire       player_sync_t player,
    input  wire       four_way,
    input  wire       rotate,
    output game_joy_t game_joy
);

    localparam game_joy_t INACTIVE = {$bits(game_joy_t){ACTIVE_LOW}};

    dir_t last_dir;   // Last single direction seen in 4-way mode
    dir_t dir_4way;
    dir_t dir_filt;
    dir_t dir_rot;
    dir_t dir_out;

    always_comb begin
        if ($onehot(player.dirs))
            dir_4way = player.dirs;
        else if ((player.dirs & last_dir) != '0)
            dir_4way = last_dir;  // Diagonal keeps the held direction
        else
            dir_4way = '0;
    end

    assign dir_filt = four_way ? dir_4way : player.dirs;

    // Vertical games turn the stick a quarter
    always_comb begin
        dir_rot = dir_filt;
        if (rotate) begin
            dir_rot[DIR_UP]    = dir_filt[DIR_RIGHT];
            dir_rot[DIR_DOWN]  = dir_filt[DIR_LEFT];
            dir_rot[DIR_LEFT]  = dir_filt[DIR_UP];
            dir_rot[DIR_RIGHT] = dir_filt[DIR_DOWN];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= '0;
            game_joy <= INACTIVE;
        end else begin
            last_dir <= four_way ? dir_4way : '0;
            game_joy <= INACTIVE ^ {player.buttons, dir_rot};
        end
    end

    assign dir_out = game_joy[DIR_UP:DIR_RIGHT] ^ INACTIVE[DIR_UP:DIR_RIGHT];

    four_way_single_dir: assert property (@(posedge clk_sys) disable iff (rst)
        four_way |=> $onehot0(dir_out));

endmodule

`default_nettype wire

// File: board_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl import joy_pkg::*, regs_pkg::*; #(
    parameter int NUM_PLAYERS     = 4,
    parameter bit ACTIVE_LOW      = 1'b1,
    parameter int GAME_RST_CYCLES = 255
) (
    input  wire          clk_sys,
    input  wire          rst,
    input  wire          player_sync_t player [NUM_PLAYERS],
    input  wire          ctrl_cmd_t cmd,
    input  wire          downloading,
    input  wire          rst_req,
    output player_mask_t game_coin,
    output player_mask_t game_start,
    output logic         game_pause,
    output logic         game_rst
);

    localparam player_mask_t INACTIVE = {$bits(player_mask_t){ACTIVE_LOW}};
    localparam int CNT_W = (GAME_RST_CYCLES > 1) ? $clog2(GAME_RST_CYCLES + 1) : 1;
    localparam int PAUSE_PLAYERS = (NUM_PLAYERS < 2) ? NUM_PLAYERS : 2;

    player_mask_t coin_raw;
    player_mask_t start_raw;
    logic         joy_pause;
    logic         last_joy_pause;
    logic         rst_cause;      // Registered downloading or rst_req
    logic [CNT_W-1:0] rst_cnt;

    always_comb begin
        coin_raw  = '0;  // Missing players stay inactive
        start_raw = '0;
        joy_pause = 1'b0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            coin_raw[i]  = player[i].coin;
            start_raw[i] = player[i].start;
        end
        for (int i = 0; i < PAUSE_PLAYERS; i++)
            joy_pause = joy_pause | player[i].pause;  // Players 1 and 2 only
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_coin      <= INACTIVE;
            game_start     <= INACTIVE;
            game_pause     <= 1'b0;
            last_joy_pause <= 1'b0;
            rst_cause      <= 1'b0;
            rst_cnt        <= '0;
            game_rst       <= 1'b1;  // Counts out like any other cause
        end else begin
            game_coin      <= INACTIVE ^ coin_raw;
            game_start     <= INACTIVE ^ start_raw;
            last_joy_pause <= joy_pause;
            rst_cause      <= downloading | rst_req;

            if (downloading)
                game_pause <= 1'b0;
            else if ((joy_pause && !last_joy_pause) || cmd.pause_pulse)
                game_pause <= !game_pause;

            // Hold while a cause is present, then stretch
            if (rst_cause || cmd.reset_pulse) begin
                rst_cnt  <= '0;
                game_rst <= 1'b1;
            end else if (rst_cnt != CNT_W'(GAME_RST_CYCLES)) begin
                rst_cnt  <= rst_cnt + 1'b1;
                game_rst <= 1'b1;
            end else begin
                game_rst <= 1'b0;
            end
        end
    end

    // One cycle to register the cause, one for game_rst
    download_resets_game: assert property (@(posedge clk_sys) disable iff (rst)
        downloading |-> ##2 game_rst);

endmodule

`default_nettype wire

// File: input_board.sv
`timescale 1ns/1ps
`default_nettype none

module input_board import joy_pkg::*, regs_pkg::*; #(
    parameter int NUM_PLAYERS     = 4,
    parameter bit ACTIVE_LOW      = 1'b1,
    parameter int GAME_RST_CYCLES = 255
) (
    input  wire          clk_sys,
    input  wire          rst,
    input  wire          board_joy_t board_joy [NUM_PLAYERS],
    input  wire          downloading,
    input  wire          rst_req,
    input  wire          apb_req_t apb_req,
    output apb_rsp_t     apb_rsp,
    output wire          game_joy_t game_joy [NUM_PLAYERS],
    output player_mask_t game_coin,
    output player_mask_t game_start,
    output logic         game_pause,
    output logic         game_rst
);

    ctrl_cmd_t    cmd;
    player_sync_t player [NUM_PLAYERS];

    apb_regs u_regs (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .apb_req    ( apb_req    ),
        .apb_rsp    ( apb_rsp    ),
        .game_pause ( game_pause ),  // STATUS readback
        .game_rst   ( game_rst   ),
        .cmd        ( cmd        )
    );

    input_sync #(.NUM_PLAYERS(NUM_PLAYERS)) u_sync (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .board_joy  ( board_joy  ),
        .player     ( player     )
    );

    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
        joy_channel #(.ACTIVE_LOW(ACTIVE_LOW)) u_channel (
            .clk_sys  ( clk_sys      ),
            .rst      ( rst          ),
            .player   ( player[i]    ),
            .four_way ( cmd.four_way ),
            .rotate   ( cmd.rotate   ),
            .game_joy ( game_joy[i]  )
        );
    end

    board_ctrl #(
        .NUM_PLAYERS     ( NUM_PLAYERS     ),
        .ACTIVE_LOW      ( ACTIVE_LOW      ),
        .GAME_RST_CYCLES ( GAME_RST_CYCLES )
    ) u_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .player      ( player      ),
        .cmd         ( cmd         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .game_coin   ( game_coin   ),
        .game_start  ( game_start  ),
        .game_pause  ( game_pause  ),
        .game_rst    ( game_rst    )
    );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD     = 10.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk_sys,
    output logic rst
);

    always #(PERIOD / 2.0) clk_sys = ~clk_sys;

    initial begin
        clk_sys = 1'b0;
        rst     = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;  // DUT still sees rst on this edge
    end

endmodule

`default_nettype wire

// File: tb_input_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_input_board import joy_pkg::*, regs_pkg::*; ();

    localparam int NUM_PLAYERS = 4;
    localparam int REC_W       = 13;  // Words per golden record
    localparam int MAX_REC     = 64;
    localparam int TIMEOUT     = 64;

    // Operation codes of the golden file
    localparam int OP_END      = 0;
    localparam int OP_STEP     = 1;
    localparam int OP_WRITE    = 2;
    localparam int OP_READ     = 3;
    localparam int OP_DOWNLOAD = 4;
    localparam int OP_WAIT_LOW = 5;
    localparam int OP_COUNT    = 6;

    logic         clk_sys;
    logic         rst;
    board_joy_t   board_joy [NUM_PLAYERS];
    logic         downloading;
    logic         rst_req;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    game_joy_t    game_joy [NUM_PLAYERS];
    player_mask_t game_coin;
    player_mask_t game_start;
    logic         game_pause;
    logic         game_rst;

    logic [15:0] golden [REC_W*MAX_REC];
    int          test_errs;
    int          total_errs;
    int          checks;
    int          tests_run;
    int          tests_bad;
    bit          aborted;

    tb_clkgen #(.PERIOD(10.0), .RST_CYCLES(3)) u_clkgen (
        .clk_sys ( clk_sys ),
        .rst     ( rst     )
    );

    input_board #(
        .NUM_PLAYERS     ( NUM_PLAYERS ),
        .ACTIVE_LOW      ( 1'b1        ),
        .GAME_RST_CYCLES ( 16          )  // Short stretch for simulation
    ) UUT (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .board_joy   ( board_joy   ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .apb_req     ( apb_req     ),
        .apb_rsp     ( apb_rsp     ),
        .game_joy    ( game_joy    ),
        .game_coin   ( game_coin   ),
        .game_start  ( game_start  ),
        .game_pause  ( game_pause  ),
        .game_rst    ( game_rst    )
    );

    function automatic string test_name(input int num);
        case (num)
            1:       return "pass-through";
            2:       return "4-way filter";
            3:       return "rotation";
            4:       return "coin and start";
            5:       return "pause";
            6:       return "soft reset";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    // A broken wait ends the run
    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR %s", what);
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        int waited;
        @(negedge clk_sys);
        apb_req.psel    = 1'b1;  // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk_sys);
        apb_req.penable = 1'b1;
        #1;
        compare_value("pready", 1, apb_rsp.pready);  // No wait states
        for (waited = 0; !apb_rsp.pready && waited < TIMEOUT; waited++) begin
            @(negedge clk_sys);
            #1;
        end
        require(apb_rsp.pready, "APB access never saw pready");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk_sys);  // Access edge
        @(negedge clk_sys);
        apb_req = '0;
    endtask

    task automatic run_step(input int base);
        @(negedge clk_sys);
        for (int p = 0; p < NUM_PLAYERS; p++)
            board_joy[p] = golden[base+2+p];
        repeat (3) @(negedge clk_sys);  // Two sync stages plus the channel
        for (int p = 0; p < NUM_PLAYERS; p++)
            compare_value($sformatf("game_joy[%0d]", p), golden[base+6+p], game_joy[p]);
        compare_value("game_coin", golden[base+10], game_coin);
        compare_value("game_start", golden[base+11], game_start);
        compare_value("game_pause", golden[base+12], game_pause);
    endtask

    task automatic run_download(input int base);
        @(negedge clk_sys);
        downloading = 1'b1;
        repeat (golden[base+2]) @(negedge clk_sys);
        compare_value("game_rst", golden[base+6], game_rst);
        downloading = 1'b0;
        @(negedge clk_sys);
        compare_value("game_pause", golden[base+12], game_pause);
    endtask

    task automatic wait_rst_low(input int limit);
        int n;
        @(negedge clk_sys);
        for (n = 0; game_rst && n < limit; n++)
            @(negedge clk_sys);
        require(!game_rst, "game_rst did not fall before the timeout");
    endtask

    // Cycles that game_rst stays high after it is first seen
    task automatic count_rst(input int base);
        int n;
        int high;
        n    = 0;
        high = 0;
        do begin
            @(negedge clk_sys);
            n++;
        end while (!game_rst && n < golden[base+2]);
        require(game_rst, "game_rst did not rise after the reset command");
        if (game_rst) begin
            @(negedge clk_sys);
            for (n = 0; game_rst && n < golden[base+2]; n++) begin
                high++;
                @(negedge clk_sys);
            end
            require(!game_rst, "game_rst stayed high past the timeout");
            compare_value("game_rst high cycles", golden[base+6], high);
        end
    endtask

    task automatic finish_test(input int num);
        if (num != 0) begin
            tests_run++;
            if (test_errs != 0)
                tests_bad++;
            $display("test %0d %s: %s, %0d checks, %0d errors", num, test_name(num),
                     (test_errs == 0) ? "ok" : "FAILED", checks, test_errs);
        end
        total_errs += test_errs;
        test_errs  = 0;
        checks     = 0;
    endtask

    initial begin
        int        base;
        int        cur_test;
        int        n;
        apb_data_t rdata;
        logic      err;

        for (int p = 0; p < NUM_PLAYERS; p++)
            board_joy[p] = '0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        apb_req     = '0;
        test_errs   = 0;
        total_errs  = 0;
        checks      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        aborted     = 1'b0;
        cur_test    = 0;
        $readmemh("input_golden.hex", golden);

        @(negedge clk_sys);
        for (n = 0; rst && n < TIMEOUT; n++)
            @(negedge clk_sys);
        require(!rst, "reset was never released");
        if (!aborted)
            wait_rst_low(TIMEOUT);  // Power-on stretch

        for (int r = 0; r < MAX_REC && !aborted; r++) begin
            base = r * REC_W;
            if (golden[base+1] == OP_END)
                break;
            if (golden[base] != cur_test) begin
                finish_test(cur_test);
                cur_test = golden[base];
            end
            case (golden[base+1])
                OP_STEP:     run_step(base);
                OP_WRITE, OP_READ: begin
                    apb_access(golden[base+1] == OP_WRITE, golden[base+2], golden[base+3],
                               rdata, err);
                    if (golden[base+1] == OP_READ)
                        compare_value("prdata", golden[base+6], rdata);
                    compare_value("pslverr", golden[base+7], err);
                end
                OP_DOWNLOAD: run_download(base);
                OP_WAIT_LOW: wait_rst_low(golden[base+2]);
                OP_COUNT:    count_rst(base);
                default:     require(1'b0, $sformatf("unknown operation %h in record %0d",
                                                     golden[base+1], r));
            endcase
        end
        finish_test(cur_test);

        $display("summary: %0d tests run, %0d ok, %0d with errors, %0d check failures",
                 tests_run, tests_run - tests_bad, tests_bad, total_errs);
        if (total_errs == 0 && tests_run > 0 && !aborted)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: input_golden.hex
// test op | p0 p1 p2 p3 (or addr data, or cycles/limit) | joy0-3 (or rdata pslverr) | coin start pause
// op 1 step, 2 apb write, 3 apb read, 4 download, 5 wait game_rst low, 6 count game_rst high
01 1 0001 0022 03F0 000F 3FE 3DD 00F 3F0 F F 0
01 1 E005 0300 0000 0210 3FA 0FF 3FF 1EF F F 0
02 2 0000 0001 0000 0000 000 000 000 000 0 0 0
02 1 0001 0002 0000 0034 3FE 3FD 3FF 3CB F F 0
02 1 0009 0006 0005 0030 3FE 3FD 3FF 3CF F F 0
02 1 000C 0006 0005 0000 3FF 3FD 3FF 3FF F F 0
03 2 0000 0003 0000 0000 000 000 000 000 0 0 0
03 3 0000 0000 0000 0000 003 000 000 000 0 0 0
03 1 0001 0002 0008 0004 3F7 3FB 3FD 3FE F F 0
03 1 0008 0004 0001 0002 3FD 3FE 3F7 3FB F F 0
03 2 0000 0000 0000 0000 000 000 000 000 0 0 0
04 1 0800 0400 0C00 0000 3FF 3FF 3FF 3FF A 9 0
04 1 0000 0000 0000 0C03 3FF 3FF 3FF 3FC 7 7 0
05 1 0000 1000 0000 0000 3FF 3FF 3FF 3FF F F 1
05 3 0004 0000 0000 0000 001 000 000 000 0 0 0
05 2 0000 0004 0000 0000 000 000 000 000 0 0 0
05 3 0004 0000 0000 0000 000 000 000 000 0 0 0
05 2 0000 0004 0000 0000 000 000 000 000 0 0 0
05 1 0000 0000 1000 0000 3FF 3FF 3FF 3FF F F 1
05 4 0004 0000 0000 0000 001 000 000 000 0 0 0
05 3 0004 0000 0000 0000 002 000 000 000 0 0 0
05 3 0008 0000 0000 0000 000 001 000 000 0 0 0
05 2 0004 0001 0000 0000 000 001 000 000 0 0 0
05 3 0000 0000 0000 0000 000 000 000 000 0 0 0
06 5 0040 0000 0000 0000 000 000 000 000 0 0 0
06 2 0000 0008 0000 0000 000 000 000 000 0 0 0
06 6 0040 0000 0000 0000 010 000 000 000 0 0 0
06 3 0004 0000 0000 0000 000 000 000 000 0 0 0
06 2 0000 0008 0000 0000 000 000 000 000 0 0 0
06 3 0004 0000 0000 0000 002 000 000 000 0 0 0
00 0 0000 0000 0000 0000 000 000 000 000 0 0 0

// File: src.f
joy_pkg.sv
regs_pkg.sv
apb_regs.sv
input_sync.sv
joy_channel.sv
board_ctrl.sv
input_board.sv
tb_clkgen.sv
tb_input_board.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_input_board
RTL_TOP   ?= input_board
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
